/* logic/fetchPkg.sv */
`default_nettype none

package fetchPkg;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [25:0] index;
    } jFmt_t;

    typedef struct packed {
        logic [5:0]  opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] offset;
    } iFmt_t;

    // same word, read as jump or immediate format by the predecoder
    typedef union packed {
        jFmt_t       jFmt;
        iFmt_t       iFmt;
        logic [31:0] raw;
    } instWord_u;

    typedef struct packed {
        logic        valid;
        logic        taken;
        logic [31:0] target;
        logic [1:0]  bimState;
    } nlpInfo_t;

    typedef struct packed {
        logic valid;
        logic taken;
    } bpdInfo_t;

    typedef struct packed {
        logic [31:0] pc;
        instWord_u   inst;
        logic        valid;
        nlpInfo_t    nlpInfo;
    } fetchSlot_t;

    typedef struct packed {
        logic [31:0] pc;
        instWord_u   inst;
        logic        valid;
        nlpInfo_t    nlpInfo;
        bpdInfo_t    bpdInfo;
        logic        isJ;
        logic        isBr;
        logic        isJr;
        logic        predTaken;
        logic [31:0] predAddr;
    } decodedSlot_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] target;
        logic [1:0]  bimState;
        logic        shouldTake;
    } nlpUpdate_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opRegimm  = 6'h01;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opBlez    = 6'h06;
    localparam logic [5:0] opBgtz    = 6'h07;
    localparam logic [5:0] fnJr      = 6'h08;  // funct under opSpecial
    localparam logic [5:0] fnJalr    = 6'h09;

    localparam logic [1:0] bimWeakTaken = 2'b01;  // no nlp state yet

endpackage

`default_nettype wire

/* logic/preDecoder.sv */
`timescale 1ns/10ps
`default_nettype none

module preDecoder (
    input  logic [31:0]         pc,
    input  fetchPkg::instWord_u inst,
    input  logic                valid,
    output logic                isJ,
    output logic                isBr,
    output logic                isJr,
    output logic [31:0]         target
);
    import fetchPkg::*;

    logic [5:0]  opcode;
    logic [31:0] pcPlus4;
    logic [31:0] branchOffset;
    logic        directJump;
    logic        regJump;
    logic        condBranch;

    assign opcode       = inst.jFmt.opcode;
    assign pcPlus4      = pc + 32'd4;
    assign branchOffset = {{14{inst.iFmt.offset[15]}}, inst.iFmt.offset, 2'b00};

    always_comb begin
        directJump = (opcode == opJ) || (opcode == opJal);
        regJump    = (opcode == opSpecial) &&
                     ((inst.raw[5:0] == fnJr) || (inst.raw[5:0] == fnJalr));
        case (opcode)
            opBeq, opBne, opBlez, opBgtz: condBranch = 1'b1;
            opRegimm: condBranch = (inst.iFmt.rt[3:1] == 3'b000);  // bltz/bgez and -al forms
            default: condBranch = 1'b0;
        endcase
    end

    assign isJ  = valid && (directJump || regJump);
    assign isJr = valid && regJump;
    assign isBr = valid && condBranch;

    // register jumps take their target from the nlp, this value is unused there
    assign target = condBranch ? pcPlus4 + branchOffset
                               : {pcPlus4[31:28], inst.jFmt.index, 2'b00};

endmodule

`default_nettype wire

/* logic/predictSelect.sv */
`timescale 1ns/10ps
`default_nettype none

module predictSelect (
    input  fetchPkg::fetchSlot_t   slot,
    input  fetchPkg::bpdInfo_t     bpd,
    input  logic                   isJ,
    input  logic                   isBr,
    input  logic                   isJr,
    input  logic [31:0]            staticTarget,
    output fetchPkg::decodedSlot_t decoded
);
    import fetchPkg::*;

    logic taken;

    always_comb begin
        if (!slot.valid) begin
            taken = 1'b0;
        end else if (isJ && !(isJr && !slot.nlpInfo.valid)) begin
            taken = 1'b1;  // unconditional, jr needs an nlp hit
        end else if (!isBr) begin
            taken = 1'b0;
        end else if (bpd.valid) begin
            taken = bpd.taken;
        end else if (slot.nlpInfo.valid) begin
            taken = slot.nlpInfo.taken;
        end else begin
            taken = 1'b0;  // both predictors miss
        end
    end

    always_comb begin
        decoded.pc        = slot.pc;
        decoded.inst      = slot.inst;
        decoded.valid     = slot.valid;
        decoded.nlpInfo   = slot.nlpInfo;
        decoded.bpdInfo   = bpd;
        decoded.isJ       = isJ;
        decoded.isBr      = isBr;
        decoded.isJr      = isJr;
        decoded.predTaken = taken;
        decoded.predAddr  = isJr ? slot.nlpInfo.target : staticTarget;
    end

endmodule

`default_nettype wire

/* logic/redirectCtrl.sv */
`timescale 1ns/10ps
`default_nettype none

module redirectCtrl (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   flush,
    input  logic                   pause,
    input  fetchPkg::decodedSlot_t dec0,
    input  fetchPkg::decodedSlot_t dec1,
    output fetchPkg::redirect_t    redirect,
    output logic                   flushReq,
    output logic                   killSlot1
);
    import fetchPkg::*;

    logic        nlpTaken0;
    logic        nlpTaken1;
    logic        mis0Taken;
    logic        mis0NotTaken;
    logic        mis1Taken;
    logic        mis1NotTaken;
    logic        enterWait;
    logic [31:0] mis1Target;
    logic        waitDelaySlot;
    logic        lastWait;
    logic [31:0] waitTarget;

    assign nlpTaken0    = dec0.nlpInfo.valid && dec0.nlpInfo.taken;
    assign nlpTaken1    = dec1.nlpInfo.valid && dec1.nlpInfo.taken;
    assign mis0Taken    = dec0.predTaken && !nlpTaken0;
    assign mis0NotTaken = !dec0.predTaken && nlpTaken0;
    assign mis1Taken    = dec1.predTaken && !nlpTaken1;
    assign mis1NotTaken = !dec1.predTaken && nlpTaken1;

    // slot 0 wins, slot 1 fix waits for its delay slot
    assign enterWait  = !mis0Taken && !mis0NotTaken &&
                        (mis1Taken || mis1NotTaken) && (dec1.isJ || dec1.isBr);
    assign mis1Target = mis1Taken ? dec1.predAddr : dec1.pc + 32'd8;

    always_comb begin
        redirect.valid = 1'b0;
        redirect.pc    = '0;
        if (flush || pause) begin
            redirect.valid = 1'b0;
        end else if (waitDelaySlot) begin
            redirect.valid = dec0.valid;  // delay slot has arrived
            redirect.pc    = waitTarget;
        end else if (mis0Taken) begin
            redirect.valid = 1'b1;
            redirect.pc    = dec0.predAddr;
        end else if (mis0NotTaken) begin
            redirect.valid = 1'b1;
            redirect.pc    = dec0.pc + 32'd8;  // skip the delay slot
        end
    end

    assign flushReq  = redirect.valid;
    assign killSlot1 = waitDelaySlot || lastWait;

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            waitDelaySlot <= 1'b0;
            lastWait      <= 1'b0;
        end else begin
            lastWait <= waitDelaySlot;
            if (pause) begin
                waitDelaySlot <= waitDelaySlot;
            end else if (waitDelaySlot) begin
                waitDelaySlot <= !dec0.valid;
            end else begin
                waitDelaySlot <= enterWait;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!waitDelaySlot && !pause && enterWait) begin
            waitTarget <= mis1Target;
        end
    end

endmodule

`default_nettype wire

/* logic/nlpUpdateGen.sv */
`timescale 1ns/10ps
`default_nettype none

module nlpUpdateGen (
    input  fetchPkg::decodedSlot_t dec0,
    input  fetchPkg::decodedSlot_t dec1,
    output fetchPkg::nlpUpdate_t   update
);
    import fetchPkg::*;

    logic          use0;
    logic          use1;
    decodedSlot_t  pick;

    // bpd has a view, or a jump whose target is actually known
    function automatic logic qualifies(input decodedSlot_t d);
        return d.valid && (d.bpdInfo.valid || (d.isJ && !(d.isJr && !d.nlpInfo.valid)));
    endfunction

    assign use0 = qualifies(dec0);
    assign use1 = qualifies(dec1);
    assign pick = use0 ? dec0 : dec1;

    always_comb begin
        update.valid      = use0 || use1;
        update.pc         = pick.pc;
        update.target     = pick.predAddr;
        update.shouldTake = pick.predTaken;
        update.bimState   = pick.nlpInfo.valid ? pick.nlpInfo.bimState : bimWeakTaken;
    end

endmodule

`default_nettype wire

/* logic/fetchStage3.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchStage3 (
    input  logic                   clk,
    input  logic                   reset,
    input  fetchPkg::fetchSlot_t   slot0,
    input  fetchPkg::fetchSlot_t   slot1,
    input  fetchPkg::bpdInfo_t     bpd0,
    input  fetchPkg::bpdInfo_t     bpd1,
    input  logic                   flush,
    input  logic                   pause,
    output fetchPkg::decodedSlot_t out0,
    output fetchPkg::decodedSlot_t out1,
    output fetchPkg::redirect_t    redirect,
    output logic                   flushReq,
    output fetchPkg::nlpUpdate_t   nlpUpdate
);
    import fetchPkg::*;

    logic         isJ0;
    logic         isBr0;
    logic         isJr0;
    logic [31:0]  target0;
    logic         isJ1;
    logic         isBr1;
    logic         isJr1;
    logic [31:0]  target1;
    decodedSlot_t dec1;
    logic         killSlot1;

    preDecoder pre0 (
        .pc     (slot0.pc),
        .inst   (slot0.inst),
        .valid  (slot0.valid),
        .isJ    (isJ0),
        .isBr   (isBr0),
        .isJr   (isJr0),
        .target (target0)
    );

    preDecoder pre1 (
        .pc     (slot1.pc),
        .inst   (slot1.inst),
        .valid  (slot1.valid),
        .isJ    (isJ1),
        .isBr   (isBr1),
        .isJr   (isJr1),
        .target (target1)
    );

    predictSelect sel0 (
        .slot         (slot0),
        .bpd          (bpd0),
        .isJ          (isJ0),
        .isBr         (isBr0),
        .isJr         (isJr0),
        .staticTarget (target0),
        .decoded      (out0)
    );

    predictSelect sel1 (
        .slot         (slot1),
        .bpd          (bpd1),
        .isJ          (isJ1),
        .isBr         (isBr1),
        .isJr         (isJr1),
        .staticTarget (target1),
        .decoded      (dec1)
    );

    redirectCtrl ctrl0 (
        .clk       (clk),
        .reset     (reset),
        .flush     (flush),
        .pause     (pause),
        .dec0      (out0),
        .dec1      (dec1),
        .redirect  (redirect),
        .flushReq  (flushReq),
        .killSlot1 (killSlot1)
    );

    nlpUpdateGen upd0 (
        .dec0   (out0),
        .dec1   (dec1),
        .update (nlpUpdate)
    );

    // slot 1 of a bundle waiting on its delay slot is dropped
    always_comb begin
        out1       = dec1;
        out1.valid = dec1.valid && !killSlot1;
    end

endmodule

`default_nettype wire

/* verif/fetchStage3_sva.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchStage3_sva (
    input logic                   clk,
    input logic                   reset,
    input logic                   flush,
    input logic                   pause,
    input fetchPkg::redirect_t    redirect,
    input logic                   flushReq,
    input fetchPkg::decodedSlot_t out1,
    input logic                   killSlot1
);
    logic killRedirect;

    assign killRedirect = redirect.valid && killSlot1;

    flushFollowsRedirect: assert property (@(posedge clk) disable iff (reset)
        flushReq == redirect.valid)
        else $error("flushReq differs from redirect valid");

    quietWhenHeld: assert property (@(posedge clk) disable iff (reset)
        (flush || pause) |-> !redirect.valid)
        else $error("redirect issued while flush or pause is high");

    // first killed redirect is the delay-slot one, the tail cycle follows it
    delaySlotTail: assert property (@(posedge clk) disable iff (reset)
        (killRedirect && !$past(killRedirect)) |=> !out1.valid)
        else $error("slot 1 valid right after a delay-slot redirect");

endmodule

bind fetchStage3 fetchStage3_sva sva0 (
    .clk       (clk),
    .reset     (reset),
    .flush     (flush),
    .pause     (pause),
    .redirect  (redirect),
    .flushReq  (flushReq),
    .out1      (out1),
    .killSlot1 (killSlot1)
);

`default_nettype wire

/* verif/fetchStage3Tb.sv */
`timescale 1ns/10ps
`default_nettype none

module fetchStage3Tb;
    import fetchPkg::*;

    localparam int    resetCycles  = 8;
    localparam int    resetTimeout = 40;
    localparam int    maxLines     = 200;  // vector file must end before this
    localparam string vectorFile   = "verif/fetchStage3_vectors.txt";

    logic         clk;
    logic         reset;
    fetchSlot_t   slot0;
    fetchSlot_t   slot1;
    bpdInfo_t     bpd0;
    bpdInfo_t     bpd1;
    logic         flush;
    logic         pause;
    decodedSlot_t out0;
    decodedSlot_t out1;
    redirect_t    redirect;
    logic         flushReq;
    nlpUpdate_t   nlpUpdate;

    int errors;
    int checks;
    int vectors;

    logic [127:0]  testName;
    logic [1599:0] lineBuf;
    logic [31:0]   pc0, inst0, nlpTgt0, pc1, inst1, nlpTgt1;
    logic [6:0]    flags0, flags1;  // valid nlpV nlpT bim bpdV bpdT
    logic [1:0]    ctrlBits;        // flush pause
    logic [6:0]    expFlags;        // redir flushReq tk0 tk1 out1V updV updTake
    logic [31:0]   expRedirPc, expAddr0, expAddr1, expUpdPc, expUpdTarget;
    logic [1:0]    expBim;

    fetchStage3 dut0 (
        .clk       (clk),
        .reset     (reset),
        .slot0     (slot0),
        .slot1     (slot1),
        .bpd0      (bpd0),
        .bpd1      (bpd1),
        .flush     (flush),
        .pause     (pause),
        .out0      (out0),
        .out1      (out1),
        .redirect  (redirect),
        .flushReq  (flushReq),
        .nlpUpdate (nlpUpdate)
    );

    always #5 clk = ~clk;

    initial begin
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;
    end

    function automatic fetchSlot_t makeSlot(input logic [31:0] pc, input logic [31:0] inst,
                                            input logic [31:0] nlpTarget, input logic [6:0] flags);
        fetchSlot_t s;
        s.pc               = pc;
        s.inst.raw         = inst;
        s.valid            = flags[6];
        s.nlpInfo.valid    = flags[5];
        s.nlpInfo.taken    = flags[4];
        s.nlpInfo.target   = nlpTarget;
        s.nlpInfo.bimState = flags[3:2];
        return s;
    endfunction

    task automatic checkValue(input logic [127:0] test, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %0s %0s: expected %0h, actual %0h", test, field, expected, actual);
        end
    endtask

    task automatic waitResetDone(output bit done);
        int cycles;
        cycles = 0;
        while (reset && cycles < resetTimeout) begin
            @(posedge clk);
            cycles++;
        end
        done = !reset;
        if (!done) begin
            $display("reset was still high after %0d cycles", resetTimeout);
        end
    endtask

    task automatic runVector();
        @(posedge clk);
        slot0 <= makeSlot(pc0, inst0, nlpTgt0, flags0);
        slot1 <= makeSlot(pc1, inst1, nlpTgt1, flags1);
        bpd0  <= flags0[1:0];
        bpd1  <= flags1[1:0];
        flush <= ctrlBits[1];
        pause <= ctrlBits[0];
        #9;  // just before the next edge
        vectors++;
        checkValue(testName, "redirect.valid", 32'(expFlags[6]), 32'(redirect.valid));
        checkValue(testName, "flushReq", 32'(expFlags[5]), 32'(flushReq));
        if (expFlags[6]) begin
            checkValue(testName, "redirect.pc", expRedirPc, redirect.pc);
        end
        checkValue(testName, "out0.predTaken", 32'(expFlags[4]), 32'(out0.predTaken));
        checkValue(testName, "out0.predAddr", expAddr0, out0.predAddr);
        checkValue(testName, "out1.predTaken", 32'(expFlags[3]), 32'(out1.predTaken));
        checkValue(testName, "out1.predAddr", expAddr1, out1.predAddr);
        checkValue(testName, "out1.valid", 32'(expFlags[2]), 32'(out1.valid));
        checkValue(testName, "nlpUpdate.valid", 32'(expFlags[1]), 32'(nlpUpdate.valid));
        if (expFlags[1]) begin  // payload only means something when valid
            checkValue(testName, "nlpUpdate.pc", expUpdPc, nlpUpdate.pc);
            checkValue(testName, "nlpUpdate.target", expUpdTarget, nlpUpdate.target);
            checkValue(testName, "nlpUpdate.bimState", 32'(expBim), 32'(nlpUpdate.bimState));
            checkValue(testName, "nlpUpdate.shouldTake", 32'(expFlags[0]),
                       32'(nlpUpdate.shouldTake));
        end
    endtask

    initial begin
        int fd;
        int lines;
        int fields;
        bit resetDone;
        clk     = 1'b0;
        reset   = 1'b1;
        slot0   = '0;
        slot1   = '0;
        bpd0    = '0;
        bpd1    = '0;
        flush   = 1'b0;
        pause   = 1'b0;
        errors  = 0;
        checks  = 0;
        vectors = 0;
        lines   = 0;
        waitResetDone(resetDone);
        if (!resetDone) begin
            errors++;
        end else begin
            fd = $fopen(vectorFile, "r");
            if (fd == 0) begin
                $display("could not open the vector file %s", vectorFile);
                errors++;
            end else begin
                while (!$feof(fd) && lines < maxLines) begin
                    lineBuf = '0;
                    if ($fgets(lineBuf, fd) != 0) begin
                        lines++;
                        fields = $sscanf(lineBuf,
                            "%s %h %h %h %b %h %h %h %b %b %b %h %h %h %h %h %b",
                            testName, pc0, inst0, nlpTgt0, flags0, pc1, inst1, nlpTgt1,
                            flags1, ctrlBits, expFlags, expRedirPc, expAddr0, expAddr1,
                            expUpdPc, expUpdTarget, expBim);
                        if (fields == 17) begin
                            runVector();
                        end else if (fields > 0 && testName[7:0] != "#") begin
                            $display("line %0d of the vector file could not be read", lines);
                            errors++;
                        end
                    end
                end
                if (!$feof(fd)) begin
                    $display("vector file did not end within %0d lines", maxLines);
                    errors++;
                end
                $fclose(fd);
            end
        end
        if (vectors == 0 && errors == 0) begin
            $display("no vectors were applied");
            errors++;
        end
        @(posedge clk);  // let the last assertions sample
        $display("vectors %0d, checks %0d, errors %0d", vectors, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/fetchStage3_vectors.txt */
# name pc0 inst0 nlpTgt0 flags0 pc1 inst1 nlpTgt1 flags1 flushPause expFlags
#   redirPc addr0 addr1 updPc updTarget updBim; flags = v nlpV nlpT bim bpdV bpdT
jdirect 100 08000400 1000 1111100 104 00000000 0 1000000 00 0010111 0 1000 0 100 1000 11
brneg 200 1022fffc 1f4 1111011 204 00000000 0 1000000 00 0010111 0 1f4 0 200 1f4 10
jrhit 300 03e00008 5000 1111100 304 00000000 0 1000000 00 0010111 0 5000 0 300 5000 11
bpdover 400 14220010 444 1111010 404 00000000 0 1000000 00 1100110 408 444 0 400 444 10
bothmiss 200 1022fffc 0 1000000 204 00000000 0 1000000 00 0000100 0 1f4 0 0 0 00
invalid 100 08000400 0 0000011 104 00000000 0 0000000 00 0000000 0 1000 0 0 0 00
mis0taken 100 0c000800 0 1000000 104 00000000 0 1000000 00 1110111 2000 2000 0 100 2000 01
waitset 600 00000000 0 1000000 604 14220010 0 1000011 00 0001111 0 0 648 604 648 01
empty1 0 00000000 0 0000000 0 00000000 0 0000000 00 0000000 0 0 0 0 0 00
empty2 0 00000000 0 0000000 0 00000000 0 0000000 00 0000000 0 0 0 0 0 00
delayslot 608 00000000 0 1000000 60c 00000000 0 1000000 00 1100000 648 0 0 0 0 00
killtail 648 00000000 0 1000000 64c 00000000 0 1000000 00 0000000 0 0 0 0 0 00
slot1back 700 00000000 0 1000000 704 00000000 0 1000000 00 0000100 0 0 0 0 0 00
waitjump 800 00000000 0 1000000 804 08000400 0 1000000 00 0001111 0 0 1000 804 1000 01
flushwait 808 00000000 0 1000000 80c 00000000 0 1000000 10 0000000 0 0 0 0 0 00
postflush 900 00000000 0 1000000 904 00000000 0 1000000 00 0000100 0 0 0 0 0 00
waitbr a00 00000000 0 1000000 a04 14220010 0 1100011 00 0001111 0 0 a48 a04 a48 00
pausewait a08 00000000 0 1000000 a0c 00000000 0 1000000 01 0000000 0 0 0 0 0 00
resume a08 00000000 0 1000000 a0c 00000000 0 1000000 00 1100000 a48 0 0 0 0 00
tailkill a48 00000000 0 1000000 a4c 00000000 0 1000000 00 0000000 0 0 0 0 0 00
updboth 200 1022fffc 1f4 1111111 204 08000400 1000 1111000 00 0011111 0 1f4 1000 200 1f4 11
bltz 400 04200008 0 1000011 404 00000000 0 1000000 00 1110111 424 424 0 400 424 01

/* src.f */
logic/fetchPkg.sv
logic/preDecoder.sv
logic/predictSelect.sv
logic/redirectCtrl.sv
logic/nlpUpdateGen.sv
logic/fetchStage3.sv
verif/fetchStage3_sva.sv
verif/fetchStage3Tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f src.f --top-module fetchStage3Tb -o simFetchStage3
./obj_dir/simFetchStage3 > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log || ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
